// ==== verilog/debug_pkg.sv ====
package debug_pkg;

    // one word from the host, as it arrives on the strobed port
    typedef logic [31:0] cmd_t;

    // mode commands, accepted only in IDLE
    localparam cmd_t CMD_LOAD = "\0lom";
    localparam cmd_t CMD_CONT = "\0com";
    localparam cmd_t CMD_STEP = "\0stm";

    // step mode commands, accepted only in STEP_WAIT
    localparam cmd_t CMD_NEXT   = "nxst";
    localparam cmd_t CMD_CANCEL = "clst";

    typedef enum logic [2:0] {
        IDLE,
        LOAD,       // host words go to instruction memory
        RUN,        // continuous advance until end is seen
        DRAIN_WAIT, // pipeline stopped, dump starts next
        STEP_WAIT,  // waiting for next step or cancel
        STEP_GO,    // single advance cycle
        DUMP        // result words going out
    } dbg_state_t;

    // retired count followed by r0 to r15
    localparam int DUMP_WORDS = 17;

endpackage

// ==== verilog/cpu_pkg.sv ====
package cpu_pkg;

    typedef logic [31:0] data_t;
    typedef logic [31:0] instr_t;
    typedef logic [3:0]  reg_idx_t;
    typedef logic [5:0]  addr_t;
    typedef logic [3:0]  op_t;

    localparam int NUM_REGS  = 16;
    localparam int MEM_DEPTH = 64;

    // end marker, opcode F
    localparam instr_t END_INSTR = 32'hFFFF_FFFF;

    localparam op_t OP_NOP  = 4'h0;
    localparam op_t OP_ADDI = 4'h1; // rd = rs + sext(imm)
    localparam op_t OP_ADD  = 4'h2;
    localparam op_t OP_SUB  = 4'h3;
    localparam op_t OP_AND  = 4'h4;
    localparam op_t OP_OR   = 4'h5;
    localparam op_t OP_XOR  = 4'h6;

    // instruction field positions, each field 4 bits wide except imm
    localparam int OP_LSB = 28;
    localparam int RD_LSB = 24;
    localparam int RS_LSB = 20;
    localparam int RT_LSB = 16;
    localparam int IMM_W  = 16;

endpackage

// ==== verilog/debug_unit.sv ====
`timescale 1ns/100ps

module debug_unit (
    input  logic              i_clk,
    input  logic              i_reset,
    input  logic              i_rx_valid,
    input  debug_pkg::cmd_t   i_rx_data,
    input  logic              i_end_seen,
    input  logic              i_dump_done,
    output logic              o_mem_we,
    output cpu_pkg::addr_t    o_mem_addr,
    output cpu_pkg::instr_t   o_mem_data,
    output logic              o_core_clear,
    output logic              o_core_advance,
    output logic              o_dump_start,
    output logic              o_busy
);

    import debug_pkg::*;
    import cpu_pkg::*;

    localparam addr_t LAST_ADDR = addr_t'(MEM_DEPTH - 1);

    dbg_state_t state;
    logic       loaded;     // a full program, end marker included, sits in memory
    logic       step_mode;  // where to return after a dump
    logic       addr_full;  // last address written, further words dropped
    addr_t      wr_addr;

    // load writes go straight through in the strobe cycle
    assign o_mem_we   = (state == LOAD) && i_rx_valid && !addr_full;
    assign o_mem_addr = wr_addr;
    assign o_mem_data = i_rx_data;

    // no advance while the clear pulse resets the pipeline
    assign o_core_advance = ((state == RUN) || (state == STEP_GO)) && !o_core_clear;

    assign o_busy = (state != IDLE) && (state != STEP_WAIT);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state        <= IDLE;
            loaded       <= 1'b0;
            step_mode    <= 1'b0;
            addr_full    <= 1'b0;
            wr_addr      <= '0;
            o_core_clear <= 1'b0;
            o_dump_start <= 1'b0;
        end else begin
            o_core_clear <= 1'b0; // both are single-cycle pulses
            o_dump_start <= 1'b0;

            case (state)
                IDLE: begin
                    if (i_rx_valid) begin
                        if (i_rx_data == CMD_LOAD) begin
                            state     <= LOAD;
                            loaded    <= 1'b0; // old program is being overwritten
                            wr_addr   <= '0;
                            addr_full <= 1'b0;
                        end else if (i_rx_data == CMD_CONT && loaded) begin
                            state        <= RUN;
                            step_mode    <= 1'b0;
                            o_core_clear <= 1'b1;
                        end else if (i_rx_data == CMD_STEP && loaded) begin
                            state        <= STEP_WAIT;
                            step_mode    <= 1'b1;
                            o_core_clear <= 1'b1;
                        end
                    end
                end

                LOAD: begin
                    if (i_rx_valid) begin
                        if (i_rx_data == END_INSTR) begin
                            state  <= IDLE;
                            loaded <= 1'b1;
                        end else if (wr_addr == LAST_ADDR) begin
                            addr_full <= 1'b1;
                        end else if (!addr_full) begin
                            wr_addr <= wr_addr + addr_t'(1);
                        end
                    end
                end

                RUN: begin
                    // end flag is stale during the clear cycle
                    if (i_end_seen && !o_core_clear)
                        state <= DRAIN_WAIT;
                end

                DRAIN_WAIT: begin
                    state        <= DUMP;
                    o_dump_start <= 1'b1;
                end

                STEP_WAIT: begin
                    if (i_rx_valid) begin
                        if (i_rx_data == CMD_NEXT)
                            state <= STEP_GO;
                        else if (i_rx_data == CMD_CANCEL)
                            state <= IDLE;
                    end
                end

                STEP_GO: begin
                    state        <= DUMP; // one advance only
                    o_dump_start <= 1'b1;
                end

                DUMP: begin
                    if (i_dump_done)
                        state <= step_mode ? STEP_WAIT : IDLE;
                end

                default: state <= IDLE;
            endcase
        end
    end

    // the pipeline is still frozen when the last dump word goes out
    a_no_advance: assert property (@(posedge i_clk) disable iff (i_reset)
        i_dump_done |-> (state == DUMP) && !o_core_advance)
        else $error("dump done in state %s", state.name());

    // a second start would restart the dump sequencer mid-burst
    a_one_start: assert property (@(posedge i_clk) disable iff (i_reset)
        i_dump_done |-> $past(o_dump_start, DUMP_WORDS))
        else $error("dump done without a matching start");

endmodule

// ==== verilog/prog_fetch.sv ====
`timescale 1ns/100ps

module prog_fetch (
    input  logic              i_clk,
    input  logic              i_reset,
    input  logic              i_we,
    input  cpu_pkg::addr_t    i_waddr,
    input  cpu_pkg::instr_t   i_wdata,
    input  logic              i_clear,
    input  logic              i_advance,
    output cpu_pkg::instr_t   o_instr
);

    import cpu_pkg::*;

    instr_t mem [MEM_DEPTH];
    addr_t  pc;
    instr_t rd_word;

    assign rd_word = mem[pc];

    // host write port
    always_ff @(posedge i_clk) begin
        if (i_we)
            mem[i_waddr] <= i_wdata;
    end

    always_ff @(posedge i_clk) begin
        if (i_reset || i_clear) begin
            pc      <= '0;
            o_instr <= '0;  // all zero is a NOP bubble
        end else if (i_advance) begin
            o_instr <= rd_word;
            // stay on the end marker so nothing behind it enters
            if (rd_word != END_INSTR)
                pc <= pc + addr_t'(1);
        end
    end

    // loading and running are separate controller modes
    a_no_write_run: assert property (@(posedge i_clk) disable iff (i_reset)
        i_we |-> !i_advance)
        else $error("memory write while the pipeline advances");

endmodule

// ==== verilog/cpu_decode.sv ====
`timescale 1ns/100ps

module cpu_decode (
    input  logic               i_clk,
    input  logic               i_reset,
    input  logic               i_clear,
    input  logic               i_advance,
    input  cpu_pkg::instr_t    i_instr,
    input  logic               i_wb_en,
    input  cpu_pkg::reg_idx_t  i_wb_idx,
    input  cpu_pkg::data_t     i_wb_data,
    input  cpu_pkg::reg_idx_t  i_dump_idx,
    output cpu_pkg::data_t     o_dump_data,
    output cpu_pkg::op_t       o_op,
    output cpu_pkg::reg_idx_t  o_rd,
    output cpu_pkg::data_t     o_opa,
    output cpu_pkg::data_t     o_opb,
    output logic               o_is_end
);

    import cpu_pkg::*;

    data_t    rf [NUM_REGS];

    op_t      f_op;
    reg_idx_t f_rd;
    reg_idx_t f_rs;
    reg_idx_t f_rt;
    data_t    imm_ext;
    data_t    rs_val;
    data_t    rt_val;

    assign f_op    = i_instr[OP_LSB +: 4];
    assign f_rd    = i_instr[RD_LSB +: 4];
    assign f_rs    = i_instr[RS_LSB +: 4];
    assign f_rt    = i_instr[RT_LSB +: 4];
    assign imm_ext = {{(32 - IMM_W){i_instr[IMM_W-1]}}, i_instr[IMM_W-1:0]};

    // bypass: execute writes the same register at this edge
    assign rs_val = (i_wb_en && i_wb_idx == f_rs) ? i_wb_data : rf[f_rs];
    assign rt_val = (i_wb_en && i_wb_idx == f_rt) ? i_wb_data : rf[f_rt];

    assign o_dump_data = rf[i_dump_idx]; // read-only port for the dump

    // register file, zeroed on every new run
    always_ff @(posedge i_clk) begin
        if (i_reset || i_clear) begin
            for (int i = 0; i < NUM_REGS; i++)
                rf[i] <= '0;
        end else if (i_wb_en) begin
            rf[i_wb_idx] <= i_wb_data;
        end
    end

    // decode register, control part
    always_ff @(posedge i_clk) begin
        if (i_reset || i_clear) begin
            o_op     <= OP_NOP;
            o_is_end <= 1'b0;
        end else if (i_advance) begin
            o_op     <= f_op;
            o_is_end <= (i_instr == END_INSTR);
        end
    end

    // payload only matters for a valid opcode
    always_ff @(posedge i_clk) begin
        if (i_advance) begin
            o_rd  <= f_rd;
            o_opa <= rs_val;
            o_opb <= (f_op == OP_ADDI) ? imm_ext : rt_val;
        end
    end

endmodule

// ==== verilog/cpu_execute.sv ====
`timescale 1ns/100ps

module cpu_execute (
    input  logic               i_clk,
    input  logic               i_reset,
    input  logic               i_clear,
    input  logic               i_advance,
    input  cpu_pkg::op_t       i_op,
    input  cpu_pkg::reg_idx_t  i_rd,
    input  cpu_pkg::data_t     i_opa,
    input  cpu_pkg::data_t     i_opb,
    input  logic               i_is_end,
    output logic               o_wb_en,
    output cpu_pkg::reg_idx_t  o_wb_idx,
    output cpu_pkg::data_t     o_wb_data,
    output logic               o_end_seen,
    output cpu_pkg::data_t     o_retired
);

    import cpu_pkg::*;

    data_t alu_res;
    logic  is_alu;  // opcode writes a register

    always_comb begin
        alu_res = '0;
        is_alu  = 1'b1;
        case (i_op)
            OP_ADDI,
            OP_ADD:  alu_res = i_opa + i_opb; // b is the immediate for ADDI
            OP_SUB:  alu_res = i_opa - i_opb;
            OP_AND:  alu_res = i_opa & i_opb;
            OP_OR:   alu_res = i_opa | i_opb;
            OP_XOR:  alu_res = i_opa ^ i_opb;
            default: is_alu  = 1'b0;          // NOP, end and unused codes
        endcase
    end

    assign o_wb_en   = i_advance && is_alu;
    assign o_wb_idx  = i_rd;
    assign o_wb_data = alu_res;

    always_ff @(posedge i_clk) begin
        if (i_reset || i_clear) begin
            o_retired  <= '0;
            o_end_seen <= 1'b0;
        end else if (i_advance) begin
            if (is_alu)
                o_retired <= o_retired + data_t'(1);
            if (i_is_end)
                o_end_seen <= 1'b1; // sticky until the next clear
        end
    end

endmodule

// ==== verilog/state_dump.sv ====
`timescale 1ns/100ps

module state_dump (
    input  logic               i_clk,
    input  logic               i_reset,
    input  logic               i_start,
    input  cpu_pkg::data_t     i_retired,
    input  cpu_pkg::data_t     i_reg_data,
    output cpu_pkg::reg_idx_t  o_reg_idx,
    output logic               o_tx_valid,
    output cpu_pkg::data_t     o_tx_data,
    output logic               o_done
);

    import debug_pkg::*;
    import cpu_pkg::*;

    logic       active;
    logic [4:0] word_cnt;   // 0 is the retired count, 1..16 are r0..r15
    logic [4:0] reg_cnt;
    data_t      retired_q;

    assign reg_cnt    = word_cnt - 5'd1;
    assign o_reg_idx  = reg_cnt[3:0];
    assign o_tx_valid = active;
    assign o_tx_data  = (word_cnt == 5'd0) ? retired_q : i_reg_data;
    assign o_done     = active && (word_cnt == 5'(DUMP_WORDS - 1));

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            active   <= 1'b0;
            word_cnt <= '0;
        end else if (!active) begin
            if (i_start) begin
                active   <= 1'b1;
                word_cnt <= '0;
            end
        end else if (o_done) begin
            active <= 1'b0;
        end else begin
            word_cnt <= word_cnt + 5'd1;
        end
    end

    // retired count for word 0
    always_ff @(posedge i_clk) begin
        if (i_start && !active)
            retired_q <= i_retired;
    end

    // a burst is exactly one dump long and starts right after its start pulse
    a_burst_len: assert property (@(posedge i_clk) disable iff (i_reset)
        $fell(o_tx_valid) |-> $past(i_start, DUMP_WORDS + 1))
        else $error("tx_valid burst not tied to a dump start");

endmodule

// ==== verilog/debug_top.sv ====
`timescale 1ns/100ps

module debug_top (
    input  logic              i_clk,
    input  logic              i_reset,
    input  logic              i_rx_valid,
    input  debug_pkg::cmd_t   i_rx_data,
    output logic              o_tx_valid,
    output cpu_pkg::data_t    o_tx_data,
    output logic              o_busy
);

    import cpu_pkg::*;

    logic     mem_we;
    addr_t    mem_addr;
    instr_t   mem_data;
    logic     core_clear;
    logic     core_advance;
    logic     dump_start;
    logic     dump_done;
    logic     end_seen;
    instr_t   f_instr;      // fetch register
    op_t      d_op;         // decode register
    reg_idx_t d_rd;
    data_t    d_opa;
    data_t    d_opb;
    logic     d_is_end;
    logic     wb_en;
    reg_idx_t wb_idx;
    data_t    wb_data;
    data_t    retired;
    reg_idx_t dump_idx;
    data_t    dump_data;

    debug_unit ctrl_i (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_rx_valid(i_rx_valid), .i_rx_data(i_rx_data),
        .i_end_seen(end_seen), .i_dump_done(dump_done),
        .o_mem_we(mem_we), .o_mem_addr(mem_addr), .o_mem_data(mem_data),
        .o_core_clear(core_clear), .o_core_advance(core_advance),
        .o_dump_start(dump_start), .o_busy(o_busy)
    );

    prog_fetch fetch_i (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_we(mem_we), .i_waddr(mem_addr), .i_wdata(mem_data),
        .i_clear(core_clear), .i_advance(core_advance), .o_instr(f_instr)
    );

    cpu_decode decode_i (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_clear(core_clear), .i_advance(core_advance), .i_instr(f_instr),
        .i_wb_en(wb_en), .i_wb_idx(wb_idx), .i_wb_data(wb_data),
        .i_dump_idx(dump_idx), .o_dump_data(dump_data),
        .o_op(d_op), .o_rd(d_rd), .o_opa(d_opa), .o_opb(d_opb), .o_is_end(d_is_end)
    );

    cpu_execute execute_i (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_clear(core_clear), .i_advance(core_advance),
        .i_op(d_op), .i_rd(d_rd), .i_opa(d_opa), .i_opb(d_opb), .i_is_end(d_is_end),
        .o_wb_en(wb_en), .o_wb_idx(wb_idx), .o_wb_data(wb_data),
        .o_end_seen(end_seen), .o_retired(retired)
    );

    state_dump dump_i (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_start(dump_start), .i_retired(retired), .i_reg_data(dump_data),
        .o_reg_idx(dump_idx), .o_tx_valid(o_tx_valid), .o_tx_data(o_tx_data),
        .o_done(dump_done)
    );

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock (
    output logic o_clk,
    output logic o_reset
);

    initial o_clk = 1'b0;
    always #10 o_clk = ~o_clk; // 20 ns period

    initial begin
        o_reset = 1'b1;
        repeat (5) @(posedge o_clk);
        @(negedge o_clk);
        o_reset = 1'b0;
    end

endmodule

// ==== test/debug_tb.sv ====
`timescale 1ns/100ps

module debug_tb;

    import debug_pkg::*;
    import cpu_pkg::*;

    localparam int MAX_LEN = 40;

    logic        clk;
    logic        reset;
    logic        rx_valid;
    logic [31:0] rx_data;
    logic        tx_valid;
    logic [31:0] tx_data;
    logic        busy;

    logic [31:0] progs [2][MAX_LEN];
    int          plen [2];
    logic [31:0] model_rf [NUM_REGS];
    logic [31:0] model_retired;
    logic [31:0] tx_q [$];  // words seen on the tx port, oldest first

    int errors      = 0;
    int tests_ok    = 0;
    int tests_bad   = 0;
    int cycles      = 0;
    int cycle_limit = 0;

    tb_clock clk_i (.o_clk(clk), .o_reset(reset));

    debug_top dut_i (
        .i_clk(clk), .i_reset(reset),
        .i_rx_valid(rx_valid), .i_rx_data(rx_data),
        .o_tx_valid(tx_valid), .o_tx_data(tx_data), .o_busy(busy)
    );

    // dump monitor
    always @(posedge clk) begin
        if (!reset && tx_valid)
            tx_q.push_back(tx_data);
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERROR %s expected %08h got %08h", name, exp, act);
            errors++;
        end
    endtask

    task automatic send_word(input logic [31:0] w);
        @(negedge clk);
        rx_valid = 1'b1;
        rx_data  = w;
        @(negedge clk);
        rx_valid = 1'b0;
    endtask

    task automatic gen_program(input int p);
        logic [31:0] w;
        logic [31:0] opr;
        plen[p] = $urandom_range(MAX_LEN, 5);
        for (int i = 0; i < plen[p]; i++) begin
            w   = $urandom();
            opr = $urandom_range(6, 0);
            w[31:28] = opr[3:0];  // only ALU opcodes and NOP
            progs[p][i] = w;
        end
    endtask

    task automatic load_program(input int p);
        send_word(CMD_LOAD);
        for (int i = 0; i < plen[p]; i++)
            send_word(progs[p][i]);
        send_word(END_INSTR);
    endtask

    // reference semantics of one instruction
    task automatic model_exec(input logic [31:0] w);
        logic [3:0]  op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        op  = w[31:28];
        a   = model_rf[w[23:20]];
        b   = model_rf[w[19:16]];
        imm = {{16{w[15]}}, w[15:0]};
        case (op)
            OP_ADDI: model_rf[w[27:24]] = a + imm;
            OP_ADD:  model_rf[w[27:24]] = a + b;
            OP_SUB:  model_rf[w[27:24]] = a - b;
            OP_AND:  model_rf[w[27:24]] = a & b;
            OP_OR:   model_rf[w[27:24]] = a | b;
            OP_XOR:  model_rf[w[27:24]] = a ^ b;
            default: ;
        endcase
        if (op >= OP_ADDI && op <= OP_XOR)
            model_retired = model_retired + 32'd1;
    endtask

    task automatic model_run(input int p, input int n);
        for (int r = 0; r < NUM_REGS; r++)
            model_rf[r] = '0;
        model_retired = '0;
        for (int i = 0; i < n; i++)
            model_exec(progs[p][i]);
    endtask

    task automatic check_dump();
        while (tx_q.size() < DUMP_WORDS)
            @(negedge clk);
        check("o_tx_data retired", model_retired, tx_q.pop_front());
        for (int r = 0; r < NUM_REGS; r++)
            check($sformatf("o_tx_data r%0d", r), model_rf[r], tx_q.pop_front());
    endtask

    task automatic wait_idle();
        while (busy)
            @(negedge clk);
    endtask

    task automatic end_test(input string name, input int start_err);
        if (errors == start_err) begin
            $display("test %s: ok", name);
            tests_ok++;
        end else begin
            $display("test %s: %0d errors", name, errors - start_err);
            tests_bad++;
        end
    endtask

    initial begin
        int   start_err;
        int   n_app;
        logic busy_hi;
        rx_valid = 1'b0;
        rx_data  = '0;
        void'($urandom(23));
        gen_program(0);
        gen_program(1);
        // every step of the first program counts as a command
        cycle_limit = (plen[0] + plen[1] + 20 * (15 + plen[0])) * 4;
        @(negedge clk);
        while (reset)
            @(negedge clk);

        start_err = errors;
        busy_hi   = 1'b0;
        send_word(CMD_CONT);
        send_word(CMD_STEP);
        send_word(32'h1234_5678);  // not a command
        repeat (50) begin
            @(negedge clk);
            busy_hi = busy_hi | busy;
        end
        check("o_busy", 32'h0, {31'b0, busy_hi});
        check("o_tx_valid words", 32'h0, 32'(tx_q.size()));
        end_test("commands without a program", start_err);

        start_err = errors;
        load_program(0);
        send_word(CMD_CONT);
        model_run(0, plen[0]);
        check_dump();
        wait_idle();
        end_test("continuous run", start_err);

        start_err = errors;
        send_word(CMD_STEP);
        for (int n = 1; n <= plen[0] + 4; n++) begin
            send_word(CMD_NEXT);
            n_app = n - 2;  // three stages, so retire lags fetch by two steps
            if (n_app < 0)
                n_app = 0;
            if (n_app > plen[0])
                n_app = plen[0];
            model_run(0, n_app);
            check_dump();
            wait_idle();
        end
        end_test("single step", start_err);

        start_err = errors;
        send_word(CMD_CANCEL);
        check("o_busy after cancel", 32'h0, {31'b0, busy});
        send_word(CMD_CONT);
        model_run(0, plen[0]);
        check_dump();
        wait_idle();
        end_test("cancel then run", start_err);

        start_err = errors;
        load_program(1);
        send_word(CMD_CONT);
        model_run(1, plen[1]);
        check_dump();
        wait_idle();
        end_test("second program", start_err);

        start_err = errors;
        send_word(CMD_CONT);
        while (tx_q.size() < DUMP_WORDS) begin
            @(negedge clk);
            if (busy && $urandom_range(1, 0) == 1) begin
                rx_valid = 1'b1;
                case ($urandom_range(5, 0))
                    0:       rx_data = CMD_LOAD;
                    1:       rx_data = CMD_STEP;
                    2:       rx_data = CMD_CONT;
                    3:       rx_data = CMD_NEXT;
                    4:       rx_data = CMD_CANCEL;
                    default: rx_data = $urandom();
                endcase
            end else begin
                rx_valid = 1'b0;
            end
        end
        rx_valid = 1'b0;
        check_dump();
        repeat (30) @(negedge clk);
        check("o_tx_valid words after dump", 32'h0, 32'(tx_q.size()));
        check("o_busy after dump", 32'h0, {31'b0, busy});
        end_test("words while busy", start_err);

        $display("tests: %0d ok, %0d failed, %0d errors", tests_ok, tests_bad, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== project.f ====
verilog/debug_pkg.sv
verilog/cpu_pkg.sv
verilog/debug_unit.sv
verilog/prog_fetch.sv
verilog/cpu_decode.sv
verilog/cpu_execute.sv
verilog/state_dump.sv
verilog/debug_top.sv
test/tb_clock.sv
test/debug_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module debug_tb -f project.f &&
{ out=$(./obj_dir/Vdebug_tb); echo "$out"; } &&
echo "$out" | grep -q '^>>> PASS$' &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }
